// ==== id_defines.svh ====
`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

////////////////////////////////////////
// Datapath widths
////////////////////////////////////////

// Data word and instruction word
`define ID_NB_REG      32

// Register index, 32 entries
`define ID_NB_REG_ADDR 5

// Opcode and function fields share one width
`define ID_NB_OPCODE   6

////////////////////////////////////////
// Instruction fields
////////////////////////////////////////

// I-type immediate
`define ID_NB_INM      16

// R-type shift amount
`define ID_NB_SHAMT    5

// J-type target, word index
`define ID_NB_J_INM    26

////////////////////////////////////////
// Control encodings
////////////////////////////////////////

// ALU operation code
`define ID_NB_ALUOP    4

// Link register for JAL
`define ID_RA_ADDR     31

`endif

// ==== id_pkg.sv ====
`include "id_defines.svh"

package id_pkg;

   typedef enum logic [`ID_NB_OPCODE-1:0] {
      R_INST = 6'b000000,
      J      = 6'b000010,
      JAL    = 6'b000011,
      BEQ    = 6'b000100,
      BNE    = 6'b000101,
      ADDI   = 6'b001001,
      SLTI   = 6'b001010,
      ANDI   = 6'b001100,
      ORI    = 6'b001101,
      XORI   = 6'b001110,
      LUI    = 6'b001111,
      LB     = 6'b100000,
      LH     = 6'b100001,
      LW     = 6'b100011,
      LBU    = 6'b100100,
      LHU    = 6'b100101,
      LWU    = 6'b100111,
      SB     = 6'b101000,
      SH     = 6'b101001,
      SW     = 6'b101011
   } opcode_e;

   typedef enum logic [`ID_NB_OPCODE-1:0] {
      FUNC_SLL  = 6'b000000,
      FUNC_SRL  = 6'b000010,
      FUNC_SRA  = 6'b000011,
      FUNC_SLLV = 6'b000100,
      FUNC_SRLV = 6'b000110,
      FUNC_SRAV = 6'b000111,
      FUNC_JR   = 6'b001000,
      FUNC_JALR = 6'b001001,
      FUNC_ADDU = 6'b100001,
      FUNC_SUBU = 6'b100011,
      FUNC_AND  = 6'b100100,
      FUNC_OR   = 6'b100101,
      FUNC_XOR  = 6'b100110,
      FUNC_NOR  = 6'b100111,
      FUNC_SLT  = 6'b101010
   } funct_e;

   typedef enum logic [`ID_NB_ALUOP-1:0] {
      ADD, SUB, AND, OR, XOR, NOR, SRL, SLL, SRA, SLA, SLT, LUI_OP
   } alu_op_e;

   typedef enum logic [1:0] {
      BYTE = 2'd0,
      HALF = 2'd1,
      WORD = 2'd2
   } dsize_e;

   ////////////////////////////////////////
   // Control words, MSB first
   ////////////////////////////////////////

   typedef struct packed {
      alu_op_e alu_op;
      logic    use_imm;
      logic    unsigned_imm;
      logic    use_shamt;
   } ex_ctrl_t;

   typedef struct packed {
      logic   rd_en;
      logic   wr_en;
      logic   unsigned_ld;
      dsize_e dsize;
   } mem_ctrl_t;

   typedef struct packed {
      logic [`ID_NB_REG_ADDR-1:0] dest;
      logic                       reg_we;
      // Result from ALU rather than memory
      logic                       from_alu;
      // Write PC+ instead of data
      logic                       link_pc;
   } wb_ctrl_t;

   typedef struct packed {
      logic is_branch;
      logic is_bne;
      logic jump_imm;
      logic jump_reg;
   } jump_kind_t;

   typedef struct packed {
      ex_ctrl_t   ex;
      mem_ctrl_t  mem;
      wb_ctrl_t   wb;
      jump_kind_t kind;
   } id_ctrl_t;

   typedef struct packed {
      logic nop;
      logic branch;
      logic jump_rs;
      logic jump_inm;
   } id_flags_t;

   ////////////////////////////////////////
   // Instruction formats
   ////////////////////////////////////////

   typedef struct packed {
      opcode_e                    opcode;
      logic [`ID_NB_REG_ADDR-1:0] rs;
      logic [`ID_NB_REG_ADDR-1:0] rt;
      logic [`ID_NB_REG_ADDR-1:0] rd;
      logic [`ID_NB_SHAMT-1:0]    shamt;
      funct_e                     funct;
   } r_fmt_t;

   typedef struct packed {
      opcode_e                    opcode;
      logic [`ID_NB_REG_ADDR-1:0] rs;
      logic [`ID_NB_REG_ADDR-1:0] rt;
      logic [`ID_NB_INM-1:0]      imm;
   } i_fmt_t;

   typedef struct packed {
      opcode_e                 opcode;
      logic [`ID_NB_J_INM-1:0] target;
   } j_fmt_t;

   // Same word, three views
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
      j_fmt_t j;
   } instr_u;

endpackage

// ==== reg_file.sv ====
`timescale 1ns/1ps

`include "id_defines.svh"

module reg_file (
   input  logic                       i_clk,
   input  logic                       i_rst,
   input  logic [`ID_NB_REG_ADDR-1:0] i_rs_addr,
   input  logic [`ID_NB_REG_ADDR-1:0] i_rt_addr,
   input  logic [`ID_NB_REG_ADDR-1:0] i_wr_addr,
   input  logic                       i_wr_en,
   input  logic [`ID_NB_REG-1:0]      i_wr_data,
   output logic [`ID_NB_REG-1:0]      o_rd_a,
   output logic [`ID_NB_REG-1:0]      o_rd_b
);

   localparam int DEPTH = 1 << `ID_NB_REG_ADDR;

   logic [`ID_NB_REG-1:0] regs [DEPTH];

   // Single write port from write-back, r0 included
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < DEPTH; i++) begin
            regs[i] <= '0;
         end
      end else if (i_wr_en) begin
         regs[i_wr_addr] <= i_wr_data;
      end
   end

   // Asynchronous reads, a same-edge write is seen next cycle
   assign o_rd_a = regs[i_rs_addr];
   assign o_rd_b = regs[i_rt_addr];

   a_wr_addr_known: assert property (
      @(posedge i_clk) disable iff (i_rst)
      i_wr_en |-> !$isunknown(i_wr_addr)
   ) else $error("register write with unknown address");

endmodule

// ==== control_decoder.sv ====
`timescale 1ns/1ps

`include "id_defines.svh"

module control_decoder
   import id_pkg::*;
(
   input  instr_u   i_instr,
   output id_ctrl_t o_ctrl
);

   opcode_e opcode;
   funct_e  funct;
   alu_op_e f_alu_op;
   logic    f_use_shamt;
   logic    f_link_pc;
   logic    f_jump_reg;
   logic    known;
   logic    to_ra;

   assign opcode = i_instr.r.opcode;
   assign funct  = i_instr.r.funct;

   function automatic dsize_e size_of(input opcode_e op);
      dsize_e size;
      case (op)
         LB, LBU, SB: size = BYTE;
         LH, LHU, SH: size = HALF;
         default:     size = WORD;
      endcase
      return size;
   endfunction

   function automatic alu_op_e imm_alu_op(input opcode_e op);
      alu_op_e alu;
      case (op)
         SLTI:    alu = SLT;
         ANDI:    alu = AND;
         ORI:     alu = OR;
         XORI:    alu = XOR;
         LUI:     alu = LUI_OP;
         default: alu = ADD;
      endcase
      return alu;
   endfunction

   ////////////////////////////////////////
   // Function field lookup
   ////////////////////////////////////////

   always_comb begin
      f_alu_op    = ADD;
      f_use_shamt = 1'b0;
      f_link_pc   = 1'b0;
      f_jump_reg  = 1'b0;
      case (funct)
         FUNC_SLL: begin
            f_alu_op    = SLL;
            f_use_shamt = 1'b1;
         end
         FUNC_SRL: begin
            f_alu_op    = SRL;
            f_use_shamt = 1'b1;
         end
         FUNC_SRA: begin
            f_alu_op    = SRA;
            f_use_shamt = 1'b1;
         end
         // Variable shifts take the amount from rs
         FUNC_SLLV: f_alu_op = SLL;
         FUNC_SRLV: f_alu_op = SRL;
         FUNC_SRAV: f_alu_op = SRA;
         FUNC_SUBU: f_alu_op = SUB;
         FUNC_AND:  f_alu_op = AND;
         FUNC_OR:   f_alu_op = OR;
         FUNC_XOR:  f_alu_op = XOR;
         FUNC_NOR:  f_alu_op = NOR;
         FUNC_SLT:  f_alu_op = SLT;
         FUNC_JR:   f_jump_reg = 1'b1;
         FUNC_JALR: begin
            f_jump_reg = 1'b1;
            f_link_pc  = 1'b1;
         end
         default:   f_alu_op = ADD;
      endcase
   end

   ////////////////////////////////////////
   // Opcode lookup
   ////////////////////////////////////////

   always_comb begin
      o_ctrl = '0;
      known  = 1'b1;
      to_ra  = 1'b0;
      case (opcode)
         R_INST: begin
            o_ctrl.ex.alu_op     = f_alu_op;
            o_ctrl.ex.use_shamt  = f_use_shamt;
            o_ctrl.wb.reg_we     = 1'b1;
            o_ctrl.wb.from_alu   = 1'b1;
            o_ctrl.wb.link_pc    = f_link_pc;
            o_ctrl.kind.jump_reg = f_jump_reg;
         end
         LB, LH, LW, LBU, LHU, LWU: begin
            o_ctrl.ex.use_imm      = 1'b1;
            o_ctrl.mem.rd_en       = 1'b1;
            o_ctrl.mem.unsigned_ld = opcode inside {LBU, LHU, LWU};
            o_ctrl.mem.dsize       = size_of(opcode);
            o_ctrl.wb.reg_we       = 1'b1;
         end
         SB, SH, SW: begin
            o_ctrl.ex.use_imm = 1'b1;
            o_ctrl.mem.wr_en  = 1'b1;
            o_ctrl.mem.dsize  = size_of(opcode);
         end
         ADDI, SLTI, ANDI, ORI, XORI, LUI: begin
            o_ctrl.ex.alu_op       = imm_alu_op(opcode);
            o_ctrl.ex.use_imm      = 1'b1;
            // Logic ops and LUI zero-extend
            o_ctrl.ex.unsigned_imm = !(opcode inside {ADDI, SLTI});
            o_ctrl.wb.reg_we       = 1'b1;
            o_ctrl.wb.from_alu     = 1'b1;
         end
         BEQ, BNE: begin
            o_ctrl.ex.use_imm     = 1'b1;
            o_ctrl.kind.is_branch = 1'b1;
            o_ctrl.kind.is_bne    = (opcode == BNE);
         end
         J: o_ctrl.kind.jump_imm = 1'b1;
         JAL: begin
            o_ctrl.kind.jump_imm = 1'b1;
            o_ctrl.wb.reg_we     = 1'b1;
            o_ctrl.wb.link_pc    = 1'b1;
            to_ra                = 1'b1;
         end
         default: known = 1'b0;
      endcase

      // Destination select, unknown opcodes stay all zero
      if (known) begin
         if (to_ra) begin
            o_ctrl.wb.dest = `ID_NB_REG_ADDR'(`ID_RA_ADDR);
         end else if (o_ctrl.ex.use_imm) begin
            o_ctrl.wb.dest = i_instr.r.rt;
         end else begin
            o_ctrl.wb.dest = i_instr.r.rd;
         end
      end
   end

endmodule

// ==== branch_resolve.sv ====
`timescale 1ns/1ps

`include "id_defines.svh"

module branch_resolve
   import id_pkg::*;
(
   input  jump_kind_t            i_kind,
   input  logic [`ID_NB_REG-1:0] i_rd_a,
   input  logic [`ID_NB_REG-1:0] i_rd_b,
   output id_flags_t             o_flags
);

   logic equal;
   logic taken;

   assign equal = (i_rd_a == i_rd_b);

   // BNE takes the inverse condition
   assign taken = i_kind.is_bne ? !equal : equal;

   ////////////////////////////////////////
   // Flush request
   ////////////////////////////////////////

   always_comb begin
      o_flags.nop      = i_kind.jump_imm
                       | i_kind.jump_reg
                       | (i_kind.is_branch & taken);
      o_flags.branch   = i_kind.is_branch;
      o_flags.jump_rs  = i_kind.jump_reg;
      o_flags.jump_inm = i_kind.jump_imm;
   end

endmodule

// ==== id_ex_reg.sv ====
`timescale 1ns/1ps

`include "id_defines.svh"

module id_ex_reg
   import id_pkg::*;
(
   input  logic                    i_clk,
   input  logic                    i_rst,
   input  id_ctrl_t                i_ctrl,
   input  id_flags_t               i_flags,
   input  logic [`ID_NB_REG-1:0]   i_pc,
   input  logic [`ID_NB_REG-1:0]   i_a,
   input  logic [`ID_NB_REG-1:0]   i_b,
   input  logic [`ID_NB_INM-1:0]   i_imm,
   input  logic [`ID_NB_SHAMT-1:0] i_shamt,
   input  logic [`ID_NB_J_INM-1:0] i_target,
   output id_ctrl_t                o_ctrl,
   output id_flags_t               o_flags,
   output logic [`ID_NB_REG-1:0]   o_pc,
   output logic [`ID_NB_REG-1:0]   o_a,
   output logic [`ID_NB_REG-1:0]   o_b,
   output logic [`ID_NB_INM-1:0]   o_imm,
   output logic [`ID_NB_SHAMT-1:0] o_shamt,
   output logic [`ID_NB_J_INM-1:0] o_target
);

   // Control, flags, PC and operands
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_ctrl  <= '0;
         o_flags <= '0;
         o_pc    <= '0;
         o_a     <= '0;
         o_b     <= '0;
      end else begin
         o_ctrl  <= i_ctrl;
         o_flags <= i_flags;
         o_pc    <= i_pc;
         o_a     <= i_a;
         o_b     <= i_b;
      end
   end

   // Instruction fields
   always_ff @(posedge i_clk) begin
      o_imm    <= i_imm;
      o_shamt  <= i_shamt;
      o_target <= i_target;
   end

   a_nop_has_cause: assert property (
      @(posedge i_clk) disable iff (i_rst)
      o_flags.nop |-> (o_flags.branch || o_flags.jump_rs || o_flags.jump_inm)
   ) else $error("flush without branch or jump");

endmodule

// ==== instr_decode.sv ====
`timescale 1ns/1ps

`include "id_defines.svh"

module instr_decode
   import id_pkg::*;
(
   input  logic                       i_clk,
   input  logic                       i_rst,
   input  instr_u                     i_instruction,
   input  logic [`ID_NB_REG-1:0]      i_pc,
   input  logic [`ID_NB_REG_ADDR-1:0] i_wr_addr,
   input  logic [`ID_NB_REG-1:0]      i_wr_data,
   input  logic                       i_wr_en,
   output ex_ctrl_t                   o_ex,
   output mem_ctrl_t                  o_mem,
   output wb_ctrl_t                   o_wb,
   output logic [`ID_NB_REG-1:0]      o_pc,
   output logic [`ID_NB_REG-1:0]      o_a,
   output logic [`ID_NB_REG-1:0]      o_b,
   output logic [`ID_NB_INM-1:0]      o_imm,
   output logic [`ID_NB_SHAMT-1:0]    o_shamt,
   output logic [`ID_NB_J_INM-1:0]    o_jump_target,
   output id_flags_t                  o_flags
);

   logic [`ID_NB_REG-1:0] rd_a;
   logic [`ID_NB_REG-1:0] rd_b;
   id_ctrl_t              ctrl;
   id_ctrl_t              ctrl_q;
   id_flags_t             flags;

   reg_file reg_file_i (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_rs_addr (i_instruction.r.rs),
      .i_rt_addr (i_instruction.r.rt),
      .i_wr_addr (i_wr_addr),
      .i_wr_en   (i_wr_en),
      .i_wr_data (i_wr_data),
      .o_rd_a    (rd_a),
      .o_rd_b    (rd_b)
   );

   control_decoder control_decoder_i (
      .i_instr (i_instruction),
      .o_ctrl  (ctrl)
   );

   branch_resolve branch_resolve_i (
      .i_kind  (ctrl.kind),
      .i_rd_a  (rd_a),
      .i_rd_b  (rd_b),
      .o_flags (flags)
   );

   id_ex_reg id_ex_reg_i (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_ctrl   (ctrl),
      .i_flags  (flags),
      .i_pc     (i_pc),
      .i_a      (rd_a),
      .i_b      (rd_b),
      .i_imm    (i_instruction.i.imm),
      .i_shamt  (i_instruction.r.shamt),
      .i_target (i_instruction.j.target),
      .o_ctrl   (ctrl_q),
      .o_flags  (o_flags),
      .o_pc     (o_pc),
      .o_a      (o_a),
      .o_b      (o_b),
      .o_imm    (o_imm),
      .o_shamt  (o_shamt),
      .o_target (o_jump_target)
   );

   // Jump kind travels on in o_flags
   assign o_ex  = ctrl_q.ex;
   assign o_mem = ctrl_q.mem;
   assign o_wb  = ctrl_q.wb;

endmodule

// ==== tb_instr_decode.sv ====
`timescale 1ns/1ps

`include "id_defines.svh"

module tb_instr_decode
   import id_pkg::*;
();

   // About 70 cycles of tests, wide margin
   localparam int MAX_CYCLES = 2000;

   logic                       i_clk;
   logic                       i_rst;
   instr_u                     i_instruction;
   logic [`ID_NB_REG-1:0]      i_pc;
   logic [`ID_NB_REG_ADDR-1:0] i_wr_addr;
   logic [`ID_NB_REG-1:0]      i_wr_data;
   logic                       i_wr_en;
   ex_ctrl_t                   o_ex;
   mem_ctrl_t                  o_mem;
   wb_ctrl_t                   o_wb;
   logic [`ID_NB_REG-1:0]      o_pc;
   logic [`ID_NB_REG-1:0]      o_a;
   logic [`ID_NB_REG-1:0]      o_b;
   logic [`ID_NB_INM-1:0]      o_imm;
   logic [`ID_NB_SHAMT-1:0]    o_shamt;
   logic [`ID_NB_J_INM-1:0]    o_jump_target;
   id_flags_t                  o_flags;

   integer                seed = 32'h6d1f;
   int                    cycles = 0;
   // Values last written through the write port
   logic [`ID_NB_REG-1:0] model [32];

   instr_decode dut_i (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_instruction (i_instruction),
      .i_pc          (i_pc),
      .i_wr_addr     (i_wr_addr),
      .i_wr_data     (i_wr_data),
      .i_wr_en       (i_wr_en),
      .o_ex          (o_ex),
      .o_mem         (o_mem),
      .o_wb          (o_wb),
      .o_pc          (o_pc),
      .o_a           (o_a),
      .o_b           (o_b),
      .o_imm         (o_imm),
      .o_shamt       (o_shamt),
      .o_jump_target (o_jump_target),
      .o_flags       (o_flags)
   );

   always #5 i_clk = ~i_clk;

   always @(posedge i_clk) begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: the run went past %0d clock cycles", MAX_CYCLES);
         $display("test failed");
         $fatal(1, "simulation stopped by timeout");
      end
   end

   ////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////

   task automatic stop_on_error();
      $display("test failed");
      $fatal(1, "stopping at first mismatch");
   endtask

   task automatic check_ex(input string name, input ex_ctrl_t exp, input ex_ctrl_t act);
      if (act !== exp) begin
         $display("[ERROR] %s ex: expected %h, actual %h", name, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_mem(input string name, input mem_ctrl_t exp, input mem_ctrl_t act);
      if (act !== exp) begin
         $display("[ERROR] %s mem: expected %h, actual %h", name, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_wb(input string name, input wb_ctrl_t exp, input wb_ctrl_t act);
      if (act !== exp) begin
         $display("[ERROR] %s wb: expected %h, actual %h", name, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_flags(input string name, input id_flags_t exp, input id_flags_t act);
      if (act !== exp) begin
         $display("[ERROR] %s flags: expected %h, actual %h", name, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
         stop_on_error();
      end
   endtask

   ////////////////////////////////////////
   // Instruction and control builders
   ////////////////////////////////////////

   function automatic instr_u r_word(input funct_e f, input logic [4:0] rs,
                                     input logic [4:0] rt, input logic [4:0] rd,
                                     input logic [4:0] shamt);
      instr_u w;
      w.r.opcode = R_INST;
      w.r.rs     = rs;
      w.r.rt     = rt;
      w.r.rd     = rd;
      w.r.shamt  = shamt;
      w.r.funct  = f;
      return w;
   endfunction

   function automatic instr_u i_word(input opcode_e op, input logic [4:0] rs,
                                     input logic [4:0] rt, input logic [15:0] imm);
      instr_u w;
      w.i.opcode = op;
      w.i.rs     = rs;
      w.i.rt     = rt;
      w.i.imm    = imm;
      return w;
   endfunction

   function automatic instr_u j_word(input opcode_e op, input logic [25:0] target);
      instr_u w;
      w.j.opcode = op;
      w.j.target = target;
      return w;
   endfunction

   function automatic ex_ctrl_t ex_word(input alu_op_e alu, input logic imm,
                                        input logic uimm, input logic shamt);
      ex_ctrl_t e;
      e.alu_op       = alu;
      e.use_imm      = imm;
      e.unsigned_imm = uimm;
      e.use_shamt    = shamt;
      return e;
   endfunction

   function automatic mem_ctrl_t mem_word(input logic rd, input logic wr,
                                          input logic uns, input dsize_e size);
      mem_ctrl_t m;
      m.rd_en       = rd;
      m.wr_en       = wr;
      m.unsigned_ld = uns;
      m.dsize       = size;
      return m;
   endfunction

   function automatic wb_ctrl_t wb_word(input logic [4:0] dest, input logic we,
                                        input logic from_alu, input logic link);
      wb_ctrl_t w;
      w.dest     = dest;
      w.reg_we   = we;
      w.from_alu = from_alu;
      w.link_pc  = link;
      return w;
   endfunction

   function automatic id_flags_t flags_word(input logic nop, input logic br,
                                            input logic jrs, input logic jinm);
      id_flags_t f;
      f.nop      = nop;
      f.branch   = br;
      f.jump_rs  = jrs;
      f.jump_inm = jinm;
      return f;
   endfunction

   ////////////////////////////////////////
   // Stimulus tasks
   ////////////////////////////////////////

   // Drive one instruction, wait one edge, check the registered result
   task automatic run_case(input string name, input instr_u instr, input ex_ctrl_t e_ex,
                           input mem_ctrl_t e_mem, input wb_ctrl_t e_wb,
                           input id_flags_t e_flags);
      logic [31:0] pc;
      pc            = $random(seed);
      i_instruction = instr;
      i_pc          = pc;
      @(posedge i_clk);
      #1;
      check_ex(name, e_ex, o_ex);
      check_mem(name, e_mem, o_mem);
      check_wb(name, e_wb, o_wb);
      check_flags(name, e_flags, o_flags);
      check_word({name, " pc"}, pc, o_pc);
   endtask

   task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
      i_wr_addr = addr;
      i_wr_data = data;
      i_wr_en   = 1'b1;
      @(posedge i_clk);
      #1;
      i_wr_en     = 1'b0;
      model[addr] = data;
   endtask

   task automatic alu_case(input string name, input funct_e f, input alu_op_e alu,
                           input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd);
      run_case(name, r_word(f, rs, rt, rd, 5'd0), ex_word(alu, 1'b0, 1'b0, 1'b0), '0,
               wb_word(rd, 1'b1, 1'b1, 1'b0), '0);
      check_word({name, " a"}, model[rs], o_a);
      check_word({name, " b"}, model[rt], o_b);
   endtask

   task automatic shift_case(input string name, input funct_e f, input alu_op_e alu,
                             input logic use_shamt);
      logic [4:0] sh;
      sh = $random(seed);
      run_case(name, r_word(f, 5'd2, 5'd3, 5'd20, sh), ex_word(alu, 1'b0, 1'b0, use_shamt),
               '0, wb_word(5'd20, 1'b1, 1'b1, 1'b0), '0);
      check_word({name, " shamt"}, {27'd0, sh}, {27'd0, o_shamt});
   endtask

   task automatic mem_case(input string name, input opcode_e op, input ex_ctrl_t e_ex,
                           input mem_ctrl_t e_mem, input logic we, input logic from_alu);
      logic [4:0]  rt;
      logic [15:0] imm;
      rt  = $random(seed);
      imm = $random(seed);
      run_case(name, i_word(op, 5'd5, rt, imm), e_ex, e_mem, wb_word(rt, we, from_alu, 1'b0),
               '0);
      check_word({name, " imm"}, {16'd0, imm}, {16'd0, o_imm});
      check_word({name, " a"}, model[5], o_a);
   endtask

   task automatic branch_case(input string name, input opcode_e op, input logic [4:0] rs,
                              input logic [4:0] rt, input logic take);
      run_case(name, i_word(op, rs, rt, 16'h0010), ex_word(ADD, 1'b1, 1'b0, 1'b0), '0,
               wb_word(rt, 1'b0, 1'b0, 1'b0), flags_word(take, 1'b1, 1'b0, 1'b0));
   endtask

   ////////////////////////////////////////
   // Tests
   ////////////////////////////////////////

   task automatic test_reset();
      i_pc = $random(seed);
      repeat (2) @(posedge i_clk);
      #1;
      check_ex("reset", '0, o_ex);
      check_mem("reset", '0, o_mem);
      check_wb("reset", '0, o_wb);
      check_flags("reset", '0, o_flags);
      check_word("reset pc", '0, o_pc);
      check_word("reset a", '0, o_a);
      check_word("reset b", '0, o_b);
      // A jump held in reset raises no flush
      i_instruction = r_word(FUNC_JALR, 5'd1, 5'd2, 5'd3, 5'd0);
      @(posedge i_clk);
      #1;
      check_wb("reset jalr", '0, o_wb);
      check_flags("reset jalr", '0, o_flags);
      check_word("reset jalr pc", '0, o_pc);
      i_rst = 1'b0;
   endtask

   task automatic test_reg_rw();
      logic [31:0] old_val;
      for (int r = 1; r <= 8; r++) begin
         write_reg(r[4:0], $random(seed));
      end
      alu_case("addu", FUNC_ADDU, ADD, 5'd1, 5'd2, 5'd10);
      alu_case("subu", FUNC_SUBU, SUB, 5'd3, 5'd4, 5'd11);
      alu_case("and", FUNC_AND, AND, 5'd5, 5'd6, 5'd12);
      alu_case("or", FUNC_OR, OR, 5'd7, 5'd8, 5'd13);
      alu_case("xor", FUNC_XOR, XOR, 5'd2, 5'd7, 5'd14);
      alu_case("nor", FUNC_NOR, NOR, 5'd4, 5'd1, 5'd15);
      alu_case("slt", FUNC_SLT, SLT, 5'd6, 5'd3, 5'd16);
      // Write on the same edge that samples the read
      old_val   = model[3];
      i_wr_addr = 5'd3;
      i_wr_data = ~old_val;
      i_wr_en   = 1'b1;
      run_case("same cycle", r_word(FUNC_ADDU, 5'd3, 5'd4, 5'd17, 5'd0),
               ex_word(ADD, 1'b0, 1'b0, 1'b0), '0, wb_word(5'd17, 1'b1, 1'b1, 1'b0), '0);
      check_word("same cycle a", old_val, o_a);
      i_wr_en  = 1'b0;
      model[3] = ~old_val;
      alu_case("after write", FUNC_ADDU, ADD, 5'd3, 5'd4, 5'd18);
   endtask

   task automatic test_shifts();
      shift_case("sll", FUNC_SLL, SLL, 1'b1);
      shift_case("srl", FUNC_SRL, SRL, 1'b1);
      shift_case("sra", FUNC_SRA, SRA, 1'b1);
      shift_case("sllv", FUNC_SLLV, SLL, 1'b0);
      shift_case("srlv", FUNC_SRLV, SRL, 1'b0);
      shift_case("srav", FUNC_SRAV, SRA, 1'b0);
   endtask

   task automatic test_mem_imm();
      ex_ctrl_t ld_ex;
      ld_ex = ex_word(ADD, 1'b1, 1'b0, 1'b0);
      mem_case("lb", LB, ld_ex, mem_word(1'b1, 1'b0, 1'b0, BYTE), 1'b1, 1'b0);
      mem_case("lh", LH, ld_ex, mem_word(1'b1, 1'b0, 1'b0, HALF), 1'b1, 1'b0);
      mem_case("lw", LW, ld_ex, mem_word(1'b1, 1'b0, 1'b0, WORD), 1'b1, 1'b0);
      mem_case("lbu", LBU, ld_ex, mem_word(1'b1, 1'b0, 1'b1, BYTE), 1'b1, 1'b0);
      mem_case("lhu", LHU, ld_ex, mem_word(1'b1, 1'b0, 1'b1, HALF), 1'b1, 1'b0);
      mem_case("lwu", LWU, ld_ex, mem_word(1'b1, 1'b0, 1'b1, WORD), 1'b1, 1'b0);
      mem_case("sb", SB, ld_ex, mem_word(1'b0, 1'b1, 1'b0, BYTE), 1'b0, 1'b0);
      mem_case("sh", SH, ld_ex, mem_word(1'b0, 1'b1, 1'b0, HALF), 1'b0, 1'b0);
      mem_case("sw", SW, ld_ex, mem_word(1'b0, 1'b1, 1'b0, WORD), 1'b0, 1'b0);
      mem_case("addi", ADDI, ld_ex, '0, 1'b1, 1'b1);
      mem_case("slti", SLTI, ex_word(SLT, 1'b1, 1'b0, 1'b0), '0, 1'b1, 1'b1);
      mem_case("andi", ANDI, ex_word(AND, 1'b1, 1'b1, 1'b0), '0, 1'b1, 1'b1);
      mem_case("ori", ORI, ex_word(OR, 1'b1, 1'b1, 1'b0), '0, 1'b1, 1'b1);
      mem_case("xori", XORI, ex_word(XOR, 1'b1, 1'b1, 1'b0), '0, 1'b1, 1'b1);
      mem_case("lui", LUI, ex_word(LUI_OP, 1'b1, 1'b1, 1'b0), '0, 1'b1, 1'b1);
      // Unlisted opcode decodes to all zero
      run_case("unknown", i_word(opcode_e'(6'h3f), 5'd1, 5'd2, 16'h1234), '0, '0, '0, '0);
   endtask

   task automatic test_branches();
      logic [31:0] v;
      v = $random(seed);
      write_reg(5'd10, v);
      write_reg(5'd11, v);
      write_reg(5'd12, v ^ 32'h1);
      branch_case("beq equal", BEQ, 5'd10, 5'd11, 1'b1);
      branch_case("beq unequal", BEQ, 5'd10, 5'd12, 1'b0);
      branch_case("bne equal", BNE, 5'd11, 5'd10, 1'b0);
      branch_case("bne unequal", BNE, 5'd12, 5'd11, 1'b1);
   endtask

   task automatic test_jumps();
      logic [25:0] tgt;
      tgt = $random(seed);
      run_case("j", j_word(J, tgt), '0, '0, wb_word(tgt[15:11], 1'b0, 1'b0, 1'b0),
               flags_word(1'b1, 1'b0, 1'b0, 1'b1));
      check_word("j target", {6'd0, tgt}, {6'd0, o_jump_target});
      tgt = $random(seed);
      run_case("jal", j_word(JAL, tgt), '0, '0, wb_word(5'd31, 1'b1, 1'b0, 1'b1),
               flags_word(1'b1, 1'b0, 1'b0, 1'b1));
      check_word("jal target", {6'd0, tgt}, {6'd0, o_jump_target});
      run_case("jr", r_word(FUNC_JR, 5'd7, 5'd0, 5'd9, 5'd0), ex_word(ADD, 1'b0, 1'b0, 1'b0),
               '0, wb_word(5'd9, 1'b1, 1'b1, 1'b0), flags_word(1'b1, 1'b0, 1'b1, 1'b0));
      check_word("jr a", model[7], o_a);
      run_case("jalr", r_word(FUNC_JALR, 5'd8, 5'd0, 5'd12, 5'd0),
               ex_word(ADD, 1'b0, 1'b0, 1'b0), '0, wb_word(5'd12, 1'b1, 1'b1, 1'b1),
               flags_word(1'b1, 1'b0, 1'b1, 1'b0));
      check_word("jalr a", model[8], o_a);
   endtask

   initial begin
      i_clk         = 1'b0;
      i_rst         = 1'b1;
      i_instruction = '0;
      i_pc          = '0;
      i_wr_addr     = '0;
      i_wr_data     = '0;
      i_wr_en       = 1'b0;
      for (int r = 0; r < 32; r++) begin
         model[r] = '0;
      end
      test_reset();
      test_reg_rw();
      test_shifts();
      test_mem_imm();
      test_branches();
      test_jumps();
      $display("test passed");
      $finish;
   end

endmodule

// ==== sim.f ====
+incdir+.
id_pkg.sv
reg_file.sv
control_decoder.sv
branch_resolve.sv
id_ex_reg.sv
instr_decode.sv
tb_instr_decode.sv

// ==== Bender.yml ====
package:
  name: instr_decode

export_include_dirs:
  - .

sources:
  - id_pkg.sv
  - reg_file.sv
  - control_decoder.sv
  - branch_resolve.sv
  - id_ex_reg.sv
  - instr_decode.sv
  - target: test
    files:
      - tb_instr_decode.sv
